// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Geometry of the 4-way, 16-set cache with one-word lines

`define CACHE_AW    32  // Address width
`define CACHE_DW    32  // Data width, one word per line
`define CACHE_WAYS  4   // Associativity
`define CACHE_SETS  16  // Number of sets
`define CACHE_IDX_W 4   // Set index, address bits 5..2
`define CACHE_TAG_W 26  // Tag, address bits 31..6
`define CACHE_BE_W  4   // One enable per data byte

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef enum logic {
        CACHE_OP_READ  = 1'b0,
        CACHE_OP_WRITE = 1'b1
    } cache_op_e;

    // Core request, only meaningful while its strobe is high
    typedef struct packed {
        cache_op_e               op;
        logic [`CACHE_AW-1:0]    addr;
        logic [`CACHE_DW-1:0]    wdata;
        logic [`CACHE_BE_W-1:0]  be;     // Byte enables for writes
    } cache_req_t;

    typedef struct packed {
        logic                    hit;
        logic [`CACHE_DW-1:0]    rdata;  // Zero on a miss
    } cache_rsp_t;

    // Result of the parallel tag compare in one set
    typedef struct packed {
        logic                            hit;
        logic [$clog2(`CACHE_WAYS)-1:0]  hit_way;
        logic                            dirty;  // Dirty bit of the hit way
    } lookup_t;

endpackage

`default_nettype wire

// ==== snoop_pkg.sv ====
`default_nettype none

`include "cache_params.svh"

package snoop_pkg;

    // Codes 3..15 are not defined and answer as a miss
    typedef enum logic [3:0] {
        SNP_READ  = 4'd0,
        SNP_RFO   = 4'd1,
        SNP_INVAL = 4'd2
    } snoop_cmd_e;

    typedef struct packed {
        snoop_cmd_e              cmd;
        logic [`CACHE_AW-1:0]    addr;
    } snoop_req_t;

    typedef struct packed {
        logic                    hit;
        logic                    dirty;
        logic [`CACHE_DW-1:0]    data;
    } snoop_rsp_t;

endpackage

`default_nettype wire

// ==== plru_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

// Three-bit tree per set
//   bit 0 selects the half holding the victim (0 = ways 0/1, 1 = ways 2/3)
//   bit 1 selects within ways 0/1, bit 2 within ways 2/3
module plru_tree (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [`CACHE_IDX_W-1:0] i_set,
    input  logic                    i_touch,
    input  logic [1:0]              i_touch_way,
    output logic [1:0]              o_victim_way
);

    logic [2:0] r_tree [`CACHE_SETS];
    logic [2:0] w_cur;

    assign w_cur = r_tree[i_set];

    // Walk the tree from the root
    always_comb begin
        if (w_cur[0]) begin
            o_victim_way = {1'b1, w_cur[2]};
        end else begin
            o_victim_way = {1'b0, w_cur[1]};
        end
    end

    // An access points the root at the other half and the half's own
    // bit at the sibling of the accessed way
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                r_tree[s] <= 3'b000;
            end
        end else if (i_touch) begin
            r_tree[i_set][0] <= ~i_touch_way[1];  // Other half
            if (i_touch_way[1]) begin
                r_tree[i_set][2] <= ~i_touch_way[0];  // Sibling in ways 2/3
            end else begin
                r_tree[i_set][1] <= ~i_touch_way[0];  // Sibling in ways 0/1
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_line_store (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // Lookup
    input  logic [`CACHE_IDX_W-1:0]          i_set,
    input  logic [`CACHE_TAG_W-1:0]          i_tag,
    output cache_pkg::lookup_t               o_lookup,
    output logic [`CACHE_DW-1:0]             o_hit_data,
    // Whole-entry write into the looked-up set
    input  logic                             i_wr_en,
    input  logic [$clog2(`CACHE_WAYS)-1:0]   i_wr_way,
    input  logic [`CACHE_TAG_W-1:0]          i_wr_tag,
    input  logic [`CACHE_DW-1:0]             i_wr_data,
    input  logic                             i_wr_valid,
    input  logic                             i_wr_dirty
);

    localparam int WAY_W = $clog2(`CACHE_WAYS);

    logic [`CACHE_TAG_W-1:0] r_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_DW-1:0]    r_data  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]  r_valid [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]  r_dirty [`CACHE_SETS];

    // Parallel compare over the four ways of the set
    // Hit data stays zero on a miss, the controller relies on it
    always_comb begin
        o_lookup   = '0;
        o_hit_data = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (r_valid[i_set][w] && (r_tag[i_set][w] == i_tag)) begin
                o_lookup.hit     = 1'b1;
                o_lookup.hit_way = WAY_W'(w);
                o_lookup.dirty   = r_dirty[i_set][w];
                o_hit_data       = r_data[i_set][w];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                r_valid[s] <= '0;
                r_dirty[s] <= '0;
            end
        end else if (i_wr_en) begin
            r_valid[i_set][i_wr_way] <= i_wr_valid;  // Cleared on invalidation
            r_dirty[i_set][i_wr_way] <= i_wr_dirty;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            r_tag[i_set][i_wr_way]  <= i_wr_tag;
            r_data[i_set][i_wr_way] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_ctrl (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // Core side
    input  logic                             i_req_valid,
    input  cache_pkg::cache_req_t            i_req,
    output logic                             o_rsp_valid,
    output cache_pkg::cache_rsp_t            o_rsp,
    // Snoop side
    input  logic                             i_snp_valid,
    input  snoop_pkg::snoop_req_t            i_snp,
    output logic                             o_snp_rsp_valid,
    output snoop_pkg::snoop_rsp_t            o_snp_rsp,
    // Line store
    output logic [`CACHE_IDX_W-1:0]          o_set,
    output logic [`CACHE_TAG_W-1:0]          o_tag,
    input  cache_pkg::lookup_t               i_lookup,
    input  logic [`CACHE_DW-1:0]             i_hit_data,
    output logic                             o_wr_en,
    output logic [$clog2(`CACHE_WAYS)-1:0]   o_wr_way,
    output logic [`CACHE_TAG_W-1:0]          o_wr_tag,
    output logic [`CACHE_DW-1:0]             o_wr_data,
    output logic                             o_wr_valid,
    output logic                             o_wr_dirty,
    // PLRU
    output logic                             o_touch,
    output logic [$clog2(`CACHE_WAYS)-1:0]   o_touch_way,
    input  logic [$clog2(`CACHE_WAYS)-1:0]   i_victim_way
);

    logic                                w_core_sel;
    logic [`CACHE_AW-1:0]                w_addr;
    logic [$clog2(`CACHE_WAYS)-1:0]      w_way;
    cache_pkg::cache_rsp_t               w_rsp;
    snoop_pkg::snoop_rsp_t               w_snp_rsp;

    function automatic logic [`CACHE_DW-1:0] byte_merge(
        input logic [`CACHE_DW-1:0]   old_word,
        input logic [`CACHE_DW-1:0]   new_word,
        input logic [`CACHE_BE_W-1:0] be
    );
        logic [`CACHE_DW-1:0] merged;
        merged = old_word;
        for (int b = 0; b < `CACHE_BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Snoop wins, a core request in the same cycle is dropped
    assign w_core_sel = i_req_valid && !i_snp_valid;
    assign w_addr     = i_snp_valid ? i_snp.addr : i_req.addr;
    assign o_set      = w_addr[`CACHE_AW-`CACHE_TAG_W-1 -: `CACHE_IDX_W];
    assign o_tag      = w_addr[`CACHE_AW-1 -: `CACHE_TAG_W];
    assign w_way      = i_lookup.hit ? i_lookup.hit_way : i_victim_way;  // Victim on a miss

    // i_hit_data is zero on a miss, so one merge covers hit and allocation
    always_comb begin
        o_wr_en     = 1'b0;
        o_wr_way    = w_way;
        o_wr_tag    = o_tag;
        o_wr_data   = i_hit_data;
        o_wr_valid  = 1'b1;
        o_wr_dirty  = i_lookup.dirty;
        o_touch     = 1'b0;
        o_touch_way = w_way;
        w_rsp       = '0;
        w_snp_rsp   = '0;
        if (i_snp_valid) begin
            case (i_snp.cmd)
                snoop_pkg::SNP_READ: begin
                    o_touch         = i_lookup.hit;
                    w_snp_rsp.hit   = i_lookup.hit;
                    w_snp_rsp.dirty = i_lookup.dirty;
                    w_snp_rsp.data  = i_hit_data;
                end
                snoop_pkg::SNP_RFO: begin
                    w_snp_rsp.hit   = i_lookup.hit;
                    w_snp_rsp.dirty = i_lookup.dirty;
                    w_snp_rsp.data  = i_hit_data;
                    o_wr_en         = i_lookup.hit;  // Hand the line over
                    o_wr_valid      = 1'b0;
                    o_wr_dirty      = 1'b0;
                end
                snoop_pkg::SNP_INVAL: begin
                    w_snp_rsp.hit = i_lookup.hit;  // Hit only, no data
                    o_wr_en       = i_lookup.hit;
                    o_wr_valid    = 1'b0;
                    o_wr_dirty    = 1'b0;
                end
                default: begin
                    // Unknown command answers as a miss
                end
            endcase
        end else if (i_req_valid) begin
            w_rsp.hit   = i_lookup.hit;
            w_rsp.rdata = i_hit_data;  // Zero on a miss
            o_touch     = 1'b1;
            case (i_req.op)
                cache_pkg::CACHE_OP_READ: begin
                    o_wr_en    = !i_lookup.hit;  // Clean zero-filled allocation
                    o_wr_data  = '0;
                    o_wr_dirty = 1'b0;
                end
                cache_pkg::CACHE_OP_WRITE: begin
                    o_wr_en    = 1'b1;
                    o_wr_data  = byte_merge(i_hit_data, i_req.wdata, i_req.be);
                    o_wr_dirty = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp_valid     <= 1'b0;
            o_snp_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid     <= w_core_sel;
            o_snp_rsp_valid <= i_snp_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_core_sel) begin
            o_rsp <= w_rsp;
        end
        if (i_snp_valid) begin
            o_snp_rsp <= w_snp_rsp;
        end
    end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  cache_pkg::cache_req_t  i_req,
    output logic                   o_rsp_valid,
    output cache_pkg::cache_rsp_t  o_rsp,
    input  logic                   i_snp_valid,
    input  snoop_pkg::snoop_req_t  i_snp,
    output logic                   o_snp_rsp_valid,
    output snoop_pkg::snoop_rsp_t  o_snp_rsp
);

    logic [`CACHE_IDX_W-1:0]          w_set;
    logic [`CACHE_TAG_W-1:0]          w_tag;
    cache_pkg::lookup_t               w_lookup;
    logic [`CACHE_DW-1:0]             w_hit_data;
    logic                             w_wr_en;
    logic [$clog2(`CACHE_WAYS)-1:0]   w_wr_way;
    logic [`CACHE_TAG_W-1:0]          w_wr_tag;
    logic [`CACHE_DW-1:0]             w_wr_data;
    logic                             w_wr_valid;
    logic                             w_wr_dirty;
    logic                             w_touch;
    logic [$clog2(`CACHE_WAYS)-1:0]   w_touch_way;
    logic [$clog2(`CACHE_WAYS)-1:0]   w_victim_way;

    cache_ctrl i_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (i_req_valid),
        .i_req           (i_req),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp           (o_rsp),
        .i_snp_valid     (i_snp_valid),
        .i_snp           (i_snp),
        .o_snp_rsp_valid (o_snp_rsp_valid),
        .o_snp_rsp       (o_snp_rsp),
        .o_set           (w_set),
        .o_tag           (w_tag),
        .i_lookup        (w_lookup),
        .i_hit_data      (w_hit_data),
        .o_wr_en         (w_wr_en),
        .o_wr_way        (w_wr_way),
        .o_wr_tag        (w_wr_tag),
        .o_wr_data       (w_wr_data),
        .o_wr_valid      (w_wr_valid),
        .o_wr_dirty      (w_wr_dirty),
        .o_touch         (w_touch),
        .o_touch_way     (w_touch_way),
        .i_victim_way    (w_victim_way)
    );

    cache_line_store i_store (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_set      (w_set),
        .i_tag      (w_tag),
        .o_lookup   (w_lookup),
        .o_hit_data (w_hit_data),
        .i_wr_en    (w_wr_en),
        .i_wr_way   (w_wr_way),
        .i_wr_tag   (w_wr_tag),
        .i_wr_data  (w_wr_data),
        .i_wr_valid (w_wr_valid),
        .i_wr_dirty (w_wr_dirty)
    );

    plru_tree i_plru (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_set        (w_set),
        .i_touch      (w_touch),
        .i_touch_way  (w_touch_way),
        .o_victim_way (w_victim_way)
    );

endmodule

`default_nettype wire

// ==== tb_cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_cache_checker (
    input  logic                   i_clk,
    input  logic                   i_rsp_valid,
    input  cache_pkg::cache_rsp_t  i_rsp,
    input  logic                   i_snp_rsp_valid,
    input  snoop_pkg::snoop_rsp_t  i_snp_rsp
);

    int pass_count = 0;
    int fail_count = 0;

    // Waits for the response of one strobe and compares it
    // Dirty and data are compared only when chk_data is set
    task automatic compare_response(
        input string                 name,
        input logic                  is_snoop,
        input logic                  exp_hit,
        input logic                  exp_dirty,
        input logic [`CACHE_DW-1:0]  exp_data,
        input logic                  chk_data
    );
        logic                 seen;
        logic                 act_hit;
        logic                 act_dirty;
        logic [`CACHE_DW-1:0] act_data;
        logic                 match;
        string                exp_s;
        string                act_s;
        seen = 1'b0;
        for (int cyc = 0; cyc < 10 && !seen; cyc++) begin
            @(negedge i_clk);  // Outputs settled mid-cycle
            seen = is_snoop ? i_snp_rsp_valid : i_rsp_valid;
        end
        if (!seen) begin
            $display("%s: no response arrived within 10 cycles", name);
            fail_count++;
        end else begin
            act_hit   = is_snoop ? i_snp_rsp.hit : i_rsp.hit;
            act_dirty = is_snoop ? i_snp_rsp.dirty : 1'b0;  // Core side has no dirty
            act_data  = is_snoop ? i_snp_rsp.data : i_rsp.rdata;
            match     = (act_hit == exp_hit) &&
                        (!chk_data || ((act_dirty == exp_dirty) && (act_data == exp_data)));
            if (match) begin
                $display("PASS %s", name);
                pass_count++;
            end else begin
                exp_s = $sformatf("hit=%0b dirty=%0b data=%08h", exp_hit, exp_dirty, exp_data);
                act_s = $sformatf("hit=%0b dirty=%0b data=%08h", act_hit, act_dirty, act_data);
                $display("Mismatch %s: expected %s, actual %s", name, exp_s, act_s);
                fail_count++;
            end
        end
    endtask

endmodule

`default_nettype wire

// ==== tb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_cache_top;

    typedef struct packed {
        logic                   is_snoop;
        cache_pkg::cache_req_t  req;
        snoop_pkg::snoop_req_t  snp;
        logic                   exp_hit;
        logic                   exp_dirty;
        logic [`CACHE_DW-1:0]   exp_data;
        logic                   chk_data;  // Compare dirty and data too
    } stim_t;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   req_valid;
    cache_pkg::cache_req_t  req;
    logic                   rsp_valid;
    cache_pkg::cache_rsp_t  rsp;
    logic                   snp_valid;
    snoop_pkg::snoop_req_t  snp;
    logic                   snp_rsp_valid;
    snoop_pkg::snoop_rsp_t  snp_rsp;

    stim_t stim_q [$];
    string name_q [$];

    cache_top i_dut (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (req_valid),
        .i_req           (req),
        .o_rsp_valid     (rsp_valid),
        .o_rsp           (rsp),
        .i_snp_valid     (snp_valid),
        .i_snp           (snp),
        .o_snp_rsp_valid (snp_rsp_valid),
        .o_snp_rsp       (snp_rsp)
    );

    tb_cache_checker i_checker (
        .i_clk           (i_clk),
        .i_rsp_valid     (rsp_valid),
        .i_rsp           (rsp),
        .i_snp_rsp_valid (snp_rsp_valid),
        .i_snp_rsp       (snp_rsp)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Tag in bits 31..6 and set in bits 5..2
    function automatic logic [`CACHE_AW-1:0] make_addr(
        input logic [`CACHE_TAG_W-1:0] tag,
        input logic [`CACHE_IDX_W-1:0] set
    );
        return {tag, set, 2'b00};
    endfunction

    task automatic add_core(
        input string                 name,
        input cache_pkg::cache_op_e  op,
        input logic [`CACHE_AW-1:0]  addr,
        input logic [`CACHE_DW-1:0]  wdata,
        input logic [`CACHE_BE_W-1:0] be,
        input logic                  hit,
        input logic [`CACHE_DW-1:0]  data,
        input logic                  chk
    );
        stim_t e;
        e           = '0;
        e.req.op    = op;
        e.req.addr  = addr;
        e.req.wdata = wdata;
        e.req.be    = be;
        e.exp_hit   = hit;
        e.exp_data  = data;
        e.chk_data  = chk;
        stim_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic add_snoop(
        input string                 name,
        input snoop_pkg::snoop_cmd_e cmd,
        input logic [`CACHE_AW-1:0]  addr,
        input logic                  hit,
        input logic                  dirty,
        input logic [`CACHE_DW-1:0]  data,
        input logic                  chk
    );
        stim_t e;
        e           = '0;
        e.is_snoop  = 1'b1;
        e.snp.cmd   = cmd;
        e.snp.addr  = addr;
        e.exp_hit   = hit;
        e.exp_dirty = dirty;
        e.exp_data  = data;
        e.chk_data  = chk;
        stim_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        // Read allocation in set 1
        add_core("rd_empty_miss", cache_pkg::CACHE_OP_READ, make_addr(26'h10, 4'd1),
                 32'h0, 4'h0, 1'b0, 32'h0, 1'b1);
        add_core("rd_repeat_hit", cache_pkg::CACHE_OP_READ, make_addr(26'h10, 4'd1),
                 32'h0, 4'h0, 1'b1, 32'h0, 1'b1);
        // Write allocation and byte merge in set 2
        add_core("wr_full_miss", cache_pkg::CACHE_OP_WRITE, make_addr(26'h20, 4'd2),
                 32'hA1B2C3D4, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("rd_written_word", cache_pkg::CACHE_OP_READ, make_addr(26'h20, 4'd2),
                 32'h0, 4'h0, 1'b1, 32'hA1B2C3D4, 1'b1);
        add_core("wr_mask_hit", cache_pkg::CACHE_OP_WRITE, make_addr(26'h20, 4'd2),
                 32'h11223344, 4'b0101, 1'b1, 32'h0, 1'b0);
        add_core("rd_merged_word", cache_pkg::CACHE_OP_READ, make_addr(26'h20, 4'd2),
                 32'h0, 4'h0, 1'b1, 32'hA122C344, 1'b1);
        // Ways of set 3 fill as 0, 2, 1, 3 and the fifth tag takes way 0
        add_core("fill_way0", cache_pkg::CACHE_OP_WRITE, make_addr(26'h31, 4'd3),
                 32'h31313131, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("fill_way2", cache_pkg::CACHE_OP_WRITE, make_addr(26'h32, 4'd3),
                 32'h32323232, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("fill_way1", cache_pkg::CACHE_OP_WRITE, make_addr(26'h33, 4'd3),
                 32'h33333333, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("fill_way3", cache_pkg::CACHE_OP_WRITE, make_addr(26'h34, 4'd3),
                 32'h34343434, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("fill_evict_way0", cache_pkg::CACHE_OP_WRITE, make_addr(26'h35, 4'd3),
                 32'h35353535, 4'hF, 1'b0, 32'h0, 1'b0);
        add_core("rd_second_tag_hit", cache_pkg::CACHE_OP_READ, make_addr(26'h32, 4'd3),
                 32'h0, 4'h0, 1'b1, 32'h32323232, 1'b1);
        add_core("rd_first_tag_miss", cache_pkg::CACHE_OP_READ, make_addr(26'h31, 4'd3),
                 32'h0, 4'h0, 1'b0, 32'h0, 1'b1);
        // Snoops
        add_snoop("snp_rd_dirty", snoop_pkg::SNP_READ, make_addr(26'h20, 4'd2),
                  1'b1, 1'b1, 32'hA122C344, 1'b1);
        add_snoop("snp_rd_clean", snoop_pkg::SNP_READ, make_addr(26'h10, 4'd1),
                  1'b1, 1'b0, 32'h0, 1'b1);
        add_snoop("snp_rd_absent", snoop_pkg::SNP_READ, make_addr(26'h77, 4'd1),
                  1'b0, 1'b0, 32'h0, 1'b1);
        add_snoop("snp_rfo_dirty", snoop_pkg::SNP_RFO, make_addr(26'h20, 4'd2),
                  1'b1, 1'b1, 32'hA122C344, 1'b1);
        add_core("rd_after_rfo_miss", cache_pkg::CACHE_OP_READ, make_addr(26'h20, 4'd2),
                 32'h0, 4'h0, 1'b0, 32'h0, 1'b1);
        add_snoop("snp_inval_hit", snoop_pkg::SNP_INVAL, make_addr(26'h34, 4'd3),
                  1'b1, 1'b0, 32'h0, 1'b0);
        add_core("rd_after_inval_miss", cache_pkg::CACHE_OP_READ, make_addr(26'h34, 4'd3),
                 32'h0, 4'h0, 1'b0, 32'h0, 1'b1);
        // Unknown command aimed at a dirty line with nonzero data
        add_snoop("snp_unknown_cmd", snoop_pkg::snoop_cmd_e'(4'b0111),
                  make_addr(26'h32, 4'd3), 1'b0, 1'b0, 32'h0, 1'b1);
        add_core("rd_after_unknown_hit", cache_pkg::CACHE_OP_READ, make_addr(26'h32, 4'd3),
                 32'h0, 4'h0, 1'b1, 32'h32323232, 1'b1);
    endtask

    // One strobe and then an idle cycle while the checker looks at the response
    task automatic apply_entry(input int n);
        stim_t e;
        e = stim_q[n];
        @(posedge i_clk);
        #2;
        if (e.is_snoop) begin
            snp_valid = 1'b1;
            snp       = e.snp;
        end else begin
            req_valid = 1'b1;
            req       = e.req;
        end
        @(posedge i_clk);
        #2;
        req_valid = 1'b0;
        snp_valid = 1'b0;
        i_checker.compare_response(name_q[n], e.is_snoop, e.exp_hit, e.exp_dirty,
                                   e.exp_data, e.chk_data);
    endtask

    initial begin
        i_rst_n   = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        snp_valid = 1'b0;
        snp       = '0;
        build_table();
        repeat (8) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        for (int n = 0; n < stim_q.size(); n++) begin
            apply_entry(n);
        end
        @(posedge i_clk);
        $display("Tests: %0d passed, %0d failed", i_checker.pass_count, i_checker.fail_count);
        if (i_checker.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        for (int cyc = 0; cyc < 2000; cyc++) begin
            @(posedge i_clk);
        end
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
cache_pkg.sv
snoop_pkg.sv
plru_tree.sv
cache_line_store.sv
cache_ctrl.sv
cache_top.sv
tb_cache_checker.sv
tb_cache_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_cache_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
